// ==== common/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// core sizing shared by the package and the rtl

`define XLEN     32            // data and address width

`define NUM_REGS 32            // integer registers x0..x31

`define RESET_PC 32'h0000_0000 // first fetch address after reset

`endif

// ==== common/rvPkg.sv ====
`include "core_params.svh"

package rvPkg;

    typedef logic [`XLEN-1:0]              word_t;      // data or address word
    typedef logic [$clog2(`NUM_REGS)-1:0]  regAddr_t;   // rs1 rs2 rd index
    typedef logic [6:0]                    opcode_t;    // instr[6:0]
    typedef logic [2:0]                    funct3_t;    // instr[14:12]
    typedef logic [2:0]                    aluOp_t;     // instruction class
    typedef logic [3:0]                    aluCtrl_t;   // alu operation
    typedef logic [2:0]                    immSrc_t;    // immediate format
    typedef logic [1:0]                    resultSrc_t; // write back select
    typedef logic [1:0]                    pcSrc_t;     // next pc select

    // decoded control lines, one bundle per instruction
    typedef struct packed {
        logic       regWrite;  // rd gets the result
        logic       memWrite;  // store strobe
        logic       aluSrc;    // alu b from immediate
        immSrc_t    immSrc;
        resultSrc_t resultSrc;
        aluOp_t     aluOp;
        logic       isBranch;  // conditional branch
    } ctrl_t;

    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_ITYPE  = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    localparam aluOp_t ALUOP_R      = 3'd0; // jalr reuses ALUOP_I with an add
    localparam aluOp_t ALUOP_I      = 3'd1;
    localparam aluOp_t ALUOP_LOAD   = 3'd2;
    localparam aluOp_t ALUOP_STORE  = 3'd3;
    localparam aluOp_t ALUOP_BRANCH = 3'd4;
    localparam aluOp_t ALUOP_JAL    = 3'd5;
    localparam aluOp_t ALUOP_LUI    = 3'd6;
    localparam aluOp_t ALUOP_AUIPC  = 3'd7;

    localparam aluCtrl_t ALU_ADD   = 4'd0;
    localparam aluCtrl_t ALU_SUB   = 4'd1;
    localparam aluCtrl_t ALU_AND   = 4'd2;
    localparam aluCtrl_t ALU_OR    = 4'd3;
    localparam aluCtrl_t ALU_XOR   = 4'd4;
    localparam aluCtrl_t ALU_SLT   = 4'd5;
    localparam aluCtrl_t ALU_SLTU  = 4'd6;
    localparam aluCtrl_t ALU_SLL   = 4'd7;
    localparam aluCtrl_t ALU_SRL   = 4'd8;
    localparam aluCtrl_t ALU_SRA   = 4'd9;
    localparam aluCtrl_t ALU_PASSB = 4'd10; // lui

    localparam immSrc_t IMM_I = 3'd0;
    localparam immSrc_t IMM_S = 3'd1;
    localparam immSrc_t IMM_B = 3'd2;
    localparam immSrc_t IMM_U = 3'd3;
    localparam immSrc_t IMM_J = 3'd4;

    localparam resultSrc_t RES_ALU   = 2'd0;
    localparam resultSrc_t RES_MEM   = 2'd1;
    localparam resultSrc_t RES_PC4   = 2'd2; // link address
    localparam resultSrc_t RES_PCIMM = 2'd3; // auipc

    localparam pcSrc_t PC_PLUS4 = 2'd0;
    localparam pcSrc_t PC_IMM   = 2'd1; // taken branch or jal
    localparam pcSrc_t PC_ALU   = 2'd3; // jalr target

endpackage

// ==== source/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  rvPkg::opcode_t opcode,       // instr[6:0]
    input  rvPkg::funct3_t funct3,       // branch condition
    input  logic           ZeroFlag,     // alu operands equal
    input  logic           NegativeFlag, // alu less than
    output rvPkg::ctrl_t   ctrl,
    output rvPkg::pcSrc_t  PCSrc
);
    import rvPkg::*;

    logic branchTaken; // condition met for this funct3
    logic isJal;
    logic isJalr;

    always_comb begin
        ctrl = '0; // unknown opcodes leave every write off
        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluOp     = ALUOP_R;    // both operands from registers
            end
            OP_ITYPE: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_I;
                ctrl.aluOp     = ALUOP_I;
            end
            OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;       // rs1 + offset
                ctrl.immSrc    = IMM_I;
                ctrl.resultSrc = RES_MEM;
                ctrl.aluOp     = ALUOP_LOAD;
            end
            OP_STORE: begin
                ctrl.memWrite  = 1'b1;       // no rd for stores
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_S;
                ctrl.aluOp     = ALUOP_STORE;
            end
            OP_BRANCH: begin
                ctrl.isBranch  = 1'b1;       // alu compares rs1 with rs2
                ctrl.immSrc    = IMM_B;
                ctrl.aluOp     = ALUOP_BRANCH;
            end
            OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_J;
                ctrl.resultSrc = RES_PC4;    // link
                ctrl.aluOp     = ALUOP_JAL;
            end
            OP_JALR: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;       // rs1 + offset is the target
                ctrl.immSrc    = IMM_I;
                ctrl.resultSrc = RES_PC4;
                ctrl.aluOp     = ALUOP_I;    // funct3 000 gives add
            end
            OP_LUI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_U;
                ctrl.aluOp     = ALUOP_LUI;  // imm passes through
            end
            OP_AUIPC: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.immSrc    = IMM_U;
                ctrl.resultSrc = RES_PCIMM;  // pc + imm from the core adder
                ctrl.aluOp     = ALUOP_AUIPC;
            end
            default: ctrl = '0;
        endcase
    end

    // flags come back from the alu in the same cycle
    always_comb begin
        case (funct3)
            3'b000:         branchTaken = ZeroFlag;      // beq
            3'b001:         branchTaken = ~ZeroFlag;     // bne
            3'b100, 3'b110: branchTaken = NegativeFlag;  // blt bltu
            3'b101, 3'b111: branchTaken = ~NegativeFlag; // bge bgeu
            default:        branchTaken = 1'b0;          // reserved encodings
        endcase
    end

    assign isJal  = (opcode == OP_JAL);
    assign isJalr = (opcode == OP_JALR);

    always_comb begin
        if (isJalr) begin
            PCSrc = PC_ALU;
        end else if (isJal || (ctrl.isBranch && branchTaken)) begin
            PCSrc = PC_IMM;
        end else begin
            PCSrc = PC_PLUS4;
        end
    end

    always_comb begin
        noWriteClash: assert final (!(ctrl.memWrite && ctrl.regWrite))
            else $error("memWrite and regWrite both set for opcode %b", opcode);
    end

endmodule

// ==== source/aluDecoder.sv ====
`timescale 1ns/10ps

module aluDecoder (
    input  rvPkg::aluOp_t   aluOp,    // instruction class
    input  rvPkg::funct3_t  funct3,
    input  logic            funct7b5, // instr[30]
    output rvPkg::aluCtrl_t aluCtrl
);
    import rvPkg::*;

    logic isRType;

    assign isRType = (aluOp == ALUOP_R);

    always_comb begin
        case (aluOp)
            ALUOP_R, ALUOP_I: begin
                case (funct3)
                    3'b000:  aluCtrl = (isRType && funct7b5) ? ALU_SUB : ALU_ADD; // no subi
                    3'b001:  aluCtrl = ALU_SLL;
                    3'b010:  aluCtrl = ALU_SLT;
                    3'b011:  aluCtrl = ALU_SLTU;
                    3'b100:  aluCtrl = ALU_XOR;
                    3'b101:  aluCtrl = funct7b5 ? ALU_SRA : ALU_SRL; // srai sets bit 30 too
                    3'b110:  aluCtrl = ALU_OR;
                    default: aluCtrl = ALU_AND;
                endcase
            end
            ALUOP_BRANCH: begin
                case (funct3)
                    3'b000, 3'b001: aluCtrl = ALU_SUB;  // equality via ZeroFlag
                    3'b110, 3'b111: aluCtrl = ALU_SLTU; // unsigned compare
                    default:        aluCtrl = ALU_SLT;  // blt bge
                endcase
            end
            ALUOP_LUI: aluCtrl = ALU_PASSB;
            ALUOP_LOAD, ALUOP_STORE, ALUOP_JAL, ALUOP_AUIPC: begin
                aluCtrl = ALU_ADD; // address or unused sum
            end
            default: aluCtrl = ALU_ADD;
        endcase
    end

endmodule

// ==== source/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  rvPkg::word_t    a,            // rs1
    input  rvPkg::word_t    b,            // rs2 or immediate
    input  rvPkg::aluCtrl_t aluCtrl,
    output rvPkg::word_t    result,
    output logic            ZeroFlag,     // a == b
    output logic            NegativeFlag  // a < b, signedness from aluCtrl
);
    import rvPkg::*;

    logic       signedLess;
    logic       unsignedLess;
    logic [4:0] shamt; // low five bits only on rv32

    assign signedLess   = ($signed(a) < $signed(b));
    assign unsignedLess = (a < b);
    assign shamt        = b[4:0];

    always_comb begin
        case (aluCtrl)
            ALU_ADD:   result = a + b;
            ALU_SUB:   result = a - b;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_SLT:   result = word_t'(signedLess);
            ALU_SLTU:  result = word_t'(unsignedLess);
            ALU_SLL:   result = a << shamt;
            ALU_SRL:   result = a >> shamt;
            ALU_SRA:   result = word_t'($signed(a) >>> shamt); // sign fill
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    assign ZeroFlag = (a == b);

    // bltu and bgeu run sltu, all other compares are signed
    assign NegativeFlag = (aluCtrl == ALU_SLTU) ? unsignedLess : signedLess;

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module regFile (
    input  logic           clk,
    input  logic           rst,
    input  rvPkg::regAddr_t readAddr1,   // rs1
    input  rvPkg::regAddr_t readAddr2,   // rs2
    input  rvPkg::regAddr_t writeAddr,   // rd
    input  logic           writeEnable,
    input  rvPkg::word_t    writeValue,
    output rvPkg::word_t    readData1,
    output rvPkg::word_t    readData2
);
    import rvPkg::*;

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeValue; // x0 writes dropped here
        end
    end

    assign readData1 = regs[readAddr1]; // combinational read
    assign readData2 = regs[readAddr2];

    x0ReadsZero: assert property (
        @(posedge clk) disable iff (rst)
        ((readAddr1 != '0) || (readData1 == '0)) &&
        ((readAddr2 != '0) || (readData2 == '0))
    ) else $error("x0 read back nonzero");

endmodule

// ==== source/immExtend.sv ====
`timescale 1ns/10ps

module immExtend (
    input  rvPkg::word_t   instr,
    input  rvPkg::immSrc_t immSrc, // format from the control unit
    output rvPkg::word_t   imm
);
    import rvPkg::*;

    logic sign;

    assign sign = instr[31]; // every format signs from bit 31

    always_comb begin
        case (immSrc)
            IMM_I: imm = {{20{sign}}, instr[31:20]};
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B: begin
                imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0}; // even offset
            end
            IMM_U: imm = {instr[31:12], 12'b0};
            IMM_J: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== source/riscvCore.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module riscvCore (
    input  logic         clk,
    input  logic         rst,
    output rvPkg::word_t instrAddr, // fetch address, the pc
    input  rvPkg::word_t instr,     // combinational fetch data
    output rvPkg::word_t dataAddr,
    output rvPkg::word_t writeData,
    output logic         dataWrite, // one cycle store strobe
    input  rvPkg::word_t readData   // combinational load data
);
    import rvPkg::*;

    word_t    pc;
    word_t    pcNext;
    word_t    pcPlus4;
    word_t    pcTarget;  // pc + imm for branch jal auipc
    word_t    imm;
    word_t    rs1Data;
    word_t    rs2Data;
    word_t    srcB;
    word_t    aluResult;
    word_t    result;    // write back value
    ctrl_t    ctrl;
    pcSrc_t   pcSrc;
    aluCtrl_t aluCtrl;
    logic     zeroFlag;
    logic     negativeFlag;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext; // one instruction per clock
        end
    end

    assign pcPlus4  = pc + word_t'(4);
    assign pcTarget = pc + imm;

    always_comb begin
        case (pcSrc)
            PC_IMM:  pcNext = pcTarget;
            PC_ALU:  pcNext = {aluResult[$bits(word_t)-1:1], 1'b0}; // jalr clears bit 0
            default: pcNext = pcPlus4;
        endcase
    end

    controlUnit i_controlUnit (
        .opcode       (instr[6:0]),
        .funct3       (instr[14:12]),
        .ZeroFlag     (zeroFlag),
        .NegativeFlag (negativeFlag),
        .ctrl         (ctrl),
        .PCSrc        (pcSrc)
    );

    regFile i_regFile (
        .clk         (clk),
        .rst         (rst),
        .readAddr1   (instr[19:15]),
        .readAddr2   (instr[24:20]),
        .writeAddr   (instr[11:7]),
        .writeEnable (ctrl.regWrite),
        .writeValue  (result),
        .readData1   (rs1Data),
        .readData2   (rs2Data)
    );

    immExtend i_immExtend (
        .instr  (instr),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    aluDecoder i_aluDecoder (
        .aluOp    (ctrl.aluOp),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .aluCtrl  (aluCtrl)
    );

    assign srcB = ctrl.aluSrc ? imm : rs2Data;

    alu i_alu (
        .a            (rs1Data),
        .b            (srcB),
        .aluCtrl      (aluCtrl),
        .result       (aluResult),
        .ZeroFlag     (zeroFlag),
        .NegativeFlag (negativeFlag)
    );

    always_comb begin
        case (ctrl.resultSrc)
            RES_ALU:   result = aluResult;
            RES_MEM:   result = readData;
            RES_PC4:   result = pcPlus4;   // jal jalr link
            RES_PCIMM: result = pcTarget;  // auipc
            default:   result = aluResult;
        endcase
    end

    assign instrAddr = pc;
    assign dataAddr  = aluResult;       // rs1 + offset
    assign writeData = rs2Data;
    assign dataWrite = ctrl.memWrite & ~rst; // no stores while in reset

    pcAligned: assert property (
        @(posedge clk) disable iff (rst) (pc[1:0] == 2'b00)
    ) else $error("pc %h not word aligned", pc);

endmodule

// ==== test/tbCore.sv ====
`timescale 1ns/10ps
`include "core_params.svh"

module tbCore;
    import rvPkg::*;

    typedef struct packed {
        word_t addr;   // byte address of the store
        word_t value;
    } storeRec_t;

    logic  clk;
    logic  rst;
    word_t instrAddr;
    word_t instr;
    word_t dataAddr;
    word_t writeData;
    logic  dataWrite;
    word_t readData;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       model [32];   // architectural register model
    word_t       expPc [$];    // pc of every executed instruction, in order
    storeRec_t   expStores [$];
    word_t       pcModel;      // builder's program counter
    word_t       storeAddr;    // next free result slot
    logic [15:0] lfsr;
    int          cycleLimit;
    int          runCycles = 0;
    int          edgeCount = 0;
    logic        lastRst = 1'b1;

    riscvCore i_dut (
        .clk       (clk),
        .rst       (rst),
        .instrAddr (instrAddr),
        .instr     (instr),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .dataWrite (dataWrite),
        .readData  (readData)
    );

    always #4 clk = ~clk;

    assign instr    = imem[instrAddr[9:2]];  // combinational fetch
    assign readData = dmem[dataAddr[9:2]];

    always @(posedge clk) begin
        if (dataWrite) begin
            dmem[dataAddr[9:2]] <= writeData;
        end
    end

    function automatic word_t randBits(input int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // x^16+x^14+x^13+x^11+1
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t dataFill(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5A, 8'hC3}; // every word distinct
    endfunction

    function automatic word_t encR(input logic [2:0] f3, input logic alt,
                                   input logic [4:0] rd, input logic [4:0] rs1,
                                   input logic [4:0] rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_RTYPE};
    endfunction

    function automatic word_t encI(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t encS(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE}; // sw only
    endfunction

    function automatic word_t encB(input logic [12:0] imm, input logic [4:0] rs1,
                                   input logic [4:0] rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t encU(input logic [19:0] imm, input logic [4:0] rd,
                                   input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic word_t encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // rv32i integer semantics, alt is instr bit 30
    function automatic word_t refOp(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
        case (f3)
            3'd0: begin
                if (alt) return a - b;
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0]; // sign fill
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic raiseError(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic emit(input word_t word);
        imem[pcModel[9:2]] = word;
        expPc.push_back(pcModel);
        pcModel += 4;
    endtask

    task automatic setReg(input logic [4:0] rd, input word_t v);
        if (rd != 5'd0) model[rd] = v; // x0 stays zero
    endtask

    task automatic loadConst(input logic [4:0] rd, input word_t v);
        word_t upper;
        upper = v + 32'h800; // round up when addi sign extends
        emit(encU(upper[31:12], rd, OP_LUI));
        emit(encI(v[11:0], rd, 3'd0, rd, OP_ITYPE));
        setReg(rd, v);
    endtask

    task automatic storeReg(input logic [4:0] rs);
        storeRec_t rec;
        emit(encS(storeAddr[11:0], rs, 5'd0)); // x0 based address
        rec.addr  = storeAddr;
        rec.value = model[rs];
        expStores.push_back(rec);
        storeAddr += 4;
    endtask

    task automatic opReg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        emit(encR(f3, alt, rd, rs1, rs2));
        setReg(rd, refOp(f3, alt, model[rs1], model[rs2]));
    endtask

    task automatic opImm(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
        emit(encI(imm, rs1, f3, rd, OP_ITYPE));
        setReg(rd, refOp(f3, alt, model[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        logic taken;
        taken = branchRef(f3, model[rs1], model[rs2]);
        emit(encB(13'd8, rs1, rs2, f3));
        if (taken) pcModel += 4; // skipped slot keeps its padding
    endtask

    task automatic buildProgram();
        word_t       a;
        word_t       b;
        word_t       jumpPc;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] upper;
        lfsr      = 16'd62;
        pcModel   = `RESET_PC;
        storeAddr = 32'h100;
        for (int i = 0; i < 256; i++) begin
            imem[i] = encI(i[11:0], 5'd0, 3'd0, 5'd0, OP_ITYPE); // addi x0 tagged by address
            dmem[i] = dataFill(i[7:0]);
        end
        for (int i = 0; i < 32; i++) model[i] = '0;
        for (int pair = 0; pair < 2; pair++) begin
            a = randBits(32);
            b = randBits(32);
            if (pair == 1) begin
                a[31] = 1'b1; // signs differ for slt vs sltu
                b[31] = 1'b0;
            end
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            for (int k = 0; k < 10; k++) begin
                f3  = (k < 8) ? k[2:0] : ((k == 8) ? 3'd0 : 3'd5); // then sub, sra
                alt = (k >= 8);
                opReg(f3, alt, 5'd3, 5'd1, 5'd2);
                storeReg(5'd3);
            end
            for (int k = 0; k < 9; k++) begin
                f3  = (k < 8) ? k[2:0] : 3'd5; // last one is srai
                alt = (k == 8);
                if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'd0, 5'(randBits(5))};
                else imm = 12'(randBits(12));
                opImm(f3, alt, 5'd4, 5'd1, imm);
                storeReg(5'd4);
            end
        end
        storeReg(5'd1);
        emit(encI(12'(storeAddr - 4), 5'd0, 3'b010, 5'd5, OP_LOAD)); // reload what was stored
        setReg(5'd5, model[1]);
        storeReg(5'd5);
        emit(encI(12'h3F0, 5'd0, 3'b010, 5'd11, OP_LOAD)); // untouched word
        setReg(5'd11, dataFill(8'hFC));
        storeReg(5'd11);
        opImm(3'd0, 1'b0, 5'd0, 5'd1, 12'h005);
        opReg(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);
        storeReg(5'd0);
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? k[2:0] : k[2:0] + 3'd2; // beq bne blt bge bltu bgeu
            branch(f3, 5'd1, 5'd2);
            branch(f3, (k < 2) ? 5'd1 : 5'd2, 5'd1); // opposite outcome
        end
        jumpPc = pcModel;
        emit(encJ(21'd12, 5'd6));
        pcModel = jumpPc + 12;
        setReg(5'd6, jumpPc + 4);
        storeReg(5'd6);
        jumpPc = pcModel + 8; // jalr follows the two word constant load
        loadConst(5'd7, jumpPc + 13); // odd target
        emit(encI(12'd0, 5'd7, 3'd0, 5'd8, OP_JALR));
        pcModel = jumpPc + 12;
        setReg(5'd8, jumpPc + 4);
        storeReg(5'd8);
        upper = 20'(randBits(20));
        emit(encU(upper, 5'd9, OP_LUI));
        setReg(5'd9, {upper, 12'd0});
        storeReg(5'd9);
        upper = 20'(randBits(20));
        setReg(5'd10, pcModel + {upper, 12'd0});
        emit(encU(upper, 5'd10, OP_AUIPC));
        storeReg(5'd10);
        emit(encJ(21'd0, 5'd0)); // park on a self loop
    endtask

    always @(posedge clk) begin
        word_t     expectedPc;
        storeRec_t expectedStore;
        if (rst || lastRst) begin
            resetQuiet: assert (!dataWrite)
                else raiseError("dataWrite high during or right after reset");
            if (edgeCount > 0) begin
                resetPc: assert (instrAddr === `RESET_PC)
                    else raiseError($sformatf("instrAddr %h in reset, expected %h",
                                              instrAddr, `RESET_PC));
            end
        end
        if (!rst) begin
            runCycles++;
            if (expPc.size() != 0) begin
                expectedPc = expPc.pop_front();
                pcMatch: assert (instrAddr === expectedPc)
                    else raiseError($sformatf("instrAddr %h, expected %h",
                                              instrAddr, expectedPc));
            end
            if (dataWrite) begin
                storeExpected: assert (expStores.size() != 0)
                    else raiseError($sformatf("unexpected store of %h at %h",
                                              writeData, dataAddr));
                if (expStores.size() != 0) begin
                    expectedStore = expStores.pop_front();
                    storeMatch: assert ({dataAddr, writeData} === expectedStore)
                        else raiseError($sformatf("store %h at %h, expected %h at %h",
                                                  writeData, dataAddr, expectedStore.value,
                                                  expectedStore.addr));
                end
            end
        end
        lastRst = rst;
        edgeCount++;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        buildProgram();
        cycleLimit = 2 * expPc.size() + 20;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
        while ((expPc.size() != 0 || expStores.size() != 0) && runCycles < cycleLimit) begin
            @(negedge clk);
        end
        if (expPc.size() == 0 && expStores.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Timeout after %0d cycles, %0d pcs and %0d stores never seen",
                     runCycles, expPc.size(), expStores.size());
            $display("Errors found");
            $fatal(1, "program did not finish in time");
        end
    end

endmodule

// ==== src.f ====
+incdir+common
common/rvPkg.sv
source/controlUnit.sv
source/aluDecoder.sv
source/alu.sv
source/regFile.sv
source/immExtend.sv
source/riscvCore.sv
test/tbCore.sv
